/* source/keccak_pkg.sv */
// Types and constants for Keccak-f[1600] only. Host words are little-endian and two words make one lane.
`default_nettype none

package keccak_pkg;

	//////////////////////////////////////////////////
	// data types
	//////////////////////////////////////////////////

	localparam int STATE_LANES = 25;
	localparam int STATE_WORDS = 50;

	// one host data word
	typedef logic [31:0] word_t;
	// lane k holds word 2k in its low half
	typedef logic [63:0] lane_t;
	// lane index is x + 5*y
	typedef lane_t [STATE_LANES-1:0] state_t;

	// word as the host sends it
	typedef struct packed {
		word_t       data;
		logic        last;
		// valid low-order bytes, only on the last word
		logic [1:0]  byte_num;
	} host_word_t;

	// masked and padded word towards the block buffer
	typedef struct packed {
		word_t data;
		logic  last;
	} pad_word_t;

	// Keccak-512 rate and digest, in host words
	localparam int RATE_WORDS_DEFAULT   = 18;
	localparam int DIGEST_WORDS_DEFAULT = 16;

	//////////////////////////////////////////////////
	// permutation constants
	//////////////////////////////////////////////////

	localparam int ROUNDS = 24;

	// iota constants, one per round
	localparam lane_t ROUND_CONST [ROUNDS] = '{
		64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
		64'h8000_0000_0000_808A, 64'h8000_0000_8000_8000,
		64'h0000_0000_0000_808B, 64'h0000_0000_8000_0001,
		64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
		64'h0000_0000_0000_008A, 64'h0000_0000_0000_0088,
		64'h0000_0000_8000_8009, 64'h0000_0000_8000_000A,
		64'h0000_0000_8000_808B, 64'h8000_0000_0000_008B,
		64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
		64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
		64'h0000_0000_0000_800A, 64'h8000_0000_8000_000A,
		64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
		64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
	};

	// rho left-rotate amounts, indexed x + 5*y
	localparam logic [5:0] ROT_OFFSET [STATE_LANES] = '{
		6'd0,  6'd1,  6'd62, 6'd28, 6'd27,
		6'd36, 6'd44, 6'd6,  6'd55, 6'd20,
		6'd3,  6'd10, 6'd43, 6'd25, 6'd39,
		6'd41, 6'd45, 6'd15, 6'd21, 6'd8,
		6'd18, 6'd2,  6'd61, 6'd56, 6'd14
	};

endpackage

`default_nettype wire

/* source/keccak_word_intake.sv */
// Holds one host word at a time. The host must keep the four-phase order and must not raise req before ack is low.
`default_nettype none

module keccak_word_intake import keccak_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,

	// host side, four-phase req/ack
	input  logic       host_req,
	input  host_word_t host_word,
	output logic       host_ack,

	// towards the block buffer
	output logic       pad_valid,
	output pad_word_t  pad_word,
	input  logic       pad_take
);

	//////////////////////////////////////////////////
	// byte masking and first pad byte
	//////////////////////////////////////////////////

	pad_word_t padded;
	logic      accept;

	always_comb begin
		padded.last = host_word.last;
		padded.data = host_word.data;
		if (host_word.last) begin
			for (int b = 0; b < 4; b++) begin
				// keep the valid low bytes
				if (b < int'(host_word.byte_num)) begin
					padded.data[8*b +: 8] = host_word.data[8*b +: 8];
				end else if (b == int'(host_word.byte_num)) begin
					// 0x01 right after the last message byte
					padded.data[8*b +: 8] = 8'h01;
				end else begin
					padded.data[8*b +: 8] = 8'h00;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// handshake and holding register
	//////////////////////////////////////////////////

	// new word only when the slot is empty and the last ack has dropped
	assign accept = host_req & ~host_ack & ~pad_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			host_ack  <= 1'b0;
			pad_valid <= 1'b0;
		end else begin
			if (accept) begin
				host_ack  <= 1'b1;
				pad_valid <= 1'b1;
			end else begin
				// phase four once req is seen low
				if (!host_req) begin
					host_ack <= 1'b0;
				end
				// word handed to the buffer
				if (pad_valid && pad_take) begin
					pad_valid <= 1'b0;
				end
			end
		end
	end

	// payload only
	always_ff @(posedge clk) begin
		if (accept) begin
			pad_word <= padded;
		end
	end

endmodule

`default_nettype wire

/* source/keccak_block_buffer.sv */
// One-block buffer. No word is taken while a full block waits for the sponge, and RATE_WORDS must be at least 2.
`default_nettype none

module keccak_block_buffer import keccak_pkg::*; #(
	parameter int RATE_WORDS = 18
) (
	input  logic                   clk,
	input  logic                   arst_n,

	// from the intake
	input  logic                   pad_valid,
	input  pad_word_t              pad_word,
	output logic                   pad_take,

	// towards the sponge
	output logic                   block_valid,
	output word_t [RATE_WORDS-1:0] block_data,
	output logic                   block_first,
	output logic                   block_last,
	input  logic                   block_take
);

	localparam int CNT_W = $clog2(RATE_WORDS);

	logic [CNT_W-1:0]       cnt_q;
	logic                   accept;
	logic                   complete;
	word_t [RATE_WORDS-1:0] blk_d;

	// open for words until the block is complete
	assign pad_take = ~block_valid;
	assign accept   = pad_valid & pad_take;
	// message end or rate block full
	assign complete = pad_word.last | (cnt_q == CNT_W'(RATE_WORDS - 1));

	//////////////////////////////////////////////////
	// block contents
	//////////////////////////////////////////////////

	always_comb begin
		blk_d = block_data;
		for (int i = 0; i < RATE_WORDS; i++) begin
			if (i == int'(cnt_q)) begin
				blk_d[i] = pad_word.data;
			end else if (pad_word.last && i > int'(cnt_q)) begin
				// zero the tail behind the last word
				blk_d[i] = '0;
			end
		end
		// closing pad bit in the top byte of the block
		// lands in the same word as 0x01 when the last word is the final slot
		if (pad_word.last) begin
			blk_d[RATE_WORDS-1][31:24] = blk_d[RATE_WORDS-1][31:24] | 8'h80;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			block_data <= blk_d;
		end
	end

	//////////////////////////////////////////////////
	// counter and block flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q       <= '0;
			block_valid <= 1'b0;
			block_last  <= 1'b0;
			// first block after reset starts a message
			block_first <= 1'b1;
		end else begin
			if (accept) begin
				if (complete) begin
					cnt_q       <= '0;
					block_valid <= 1'b1;
					block_last  <= pad_word.last;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
			if (block_take) begin
				block_valid <= 1'b0;
				// a last block opens a new message
				block_first <= block_last;
			end
		end
	end

endmodule

`default_nettype wire

/* source/keccak_round.sv */
// One Keccak-f[1600] round, purely combinational. round_index must stay below ROUNDS.
`default_nettype none

module keccak_round import keccak_pkg::*; (
	input  state_t     state_in,
	input  logic [4:0] round_index,
	output state_t     state_out
);

	lane_t  col [5];
	lane_t  dif [5];
	state_t theta_s;
	state_t pi_s;

	// left rotate of one lane
	function automatic lane_t rotl(input lane_t v, input int unsigned n);
		if (n == 0) begin
			return v;
		end
		return (v << n) | (v >> (64 - n));
	endfunction

	//////////////////////////////////////////////////
	// theta
	//////////////////////////////////////////////////

	// column parity
	always_comb begin
		for (int x = 0; x < 5; x++) begin
			col[x] = state_in[x] ^ state_in[x+5] ^ state_in[x+10]
				^ state_in[x+15] ^ state_in[x+20];
		end
	end

	// neighbour columns, right one rotated by one
	always_comb begin
		for (int x = 0; x < 5; x++) begin
			dif[x] = col[(x+4)%5] ^ rotl(col[(x+1)%5], 1);
		end
	end

	always_comb begin
		for (int i = 0; i < STATE_LANES; i++) begin
			theta_s[i] = state_in[i] ^ dif[i%5];
		end
	end

	//////////////////////////////////////////////////
	// rho and pi
	//////////////////////////////////////////////////

	// lane (x,y) rotated and moved to (y, 2x+3y)
	always_comb begin
		pi_s = '0;
		for (int y = 0; y < 5; y++) begin
			for (int x = 0; x < 5; x++) begin
				pi_s[y + 5*((2*x + 3*y) % 5)] = rotl(theta_s[x + 5*y], ROT_OFFSET[x + 5*y]);
			end
		end
	end

	//////////////////////////////////////////////////
	// chi and iota
	//////////////////////////////////////////////////

	always_comb begin
		for (int y = 0; y < 5; y++) begin
			for (int x = 0; x < 5; x++) begin
				// nonlinear step along each row
				state_out[x + 5*y] = pi_s[x + 5*y]
					^ (~pi_s[(x+1)%5 + 5*y] & pi_s[(x+2)%5 + 5*y]);
			end
		end
		// round constant into lane (0,0)
		state_out[0] = state_out[0] ^ ROUND_CONST[round_index];
	end

endmodule

`default_nettype wire

/* source/keccak_sponge.sv */
// Absorb and permutation core. RATE_WORDS must be even and at most 50, and DIGEST_WORDS a power of two up to 32.
`default_nettype none

module keccak_sponge import keccak_pkg::*; #(
	parameter int RATE_WORDS   = 18,
	parameter int DIGEST_WORDS = 16
) (
	input  logic                            clk,
	input  logic                            arst_n,

	// from the block buffer
	input  logic                            block_valid,
	input  word_t [RATE_WORDS-1:0]          block_data,
	input  logic                            block_first,
	input  logic                            block_last,
	output logic                            block_take,

	// digest read port
	output logic                            digest_valid,
	input  logic [$clog2(DIGEST_WORDS)-1:0] digest_index,
	output word_t                           digest_word
);

	state_t                  state_q;
	state_t                  round_out;
	word_t [STATE_WORDS-1:0] absorb_words;
	word_t [STATE_WORDS-1:0] state_words;
	logic  [4:0]             round_q;
	logic                    busy_q;
	logic                    last_q;

	// single pulse, busy rises on the same edge
	assign block_take = block_valid & ~busy_q;

	//////////////////////////////////////////////////
	// absorb
	//////////////////////////////////////////////////

	always_comb begin
		// new message starts from the zero state
		if (block_first) begin
			absorb_words = '0;
		end else begin
			absorb_words = state_q;
		end
		// rate words only, capacity untouched
		for (int i = 0; i < RATE_WORDS; i++) begin
			absorb_words[i] = absorb_words[i] ^ block_data[i];
		end
	end

	keccak_round i_keccak_round (
		.state_in    (state_q),
		.round_index (round_q),
		.state_out   (round_out)
	);

	//////////////////////////////////////////////////
	// round sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q      <= '0;
			round_q      <= '0;
			busy_q       <= 1'b0;
			last_q       <= 1'b0;
			digest_valid <= 1'b0;
		end else begin
			if (block_take) begin
				state_q <= absorb_words;
				round_q <= '0;
				busy_q  <= 1'b1;
				last_q  <= block_last;
				// old digest is gone once a new message is absorbed
				if (block_first) begin
					digest_valid <= 1'b0;
				end
			end else if (busy_q) begin
				// one round per clock
				state_q <= round_out;
				if (round_q == 5'(ROUNDS - 1)) begin
					round_q <= '0;
					busy_q  <= 1'b0;
					if (last_q) begin
						digest_valid <= 1'b1;
					end
				end else begin
					round_q <= round_q + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// digest select
	//////////////////////////////////////////////////

	// word view, word 0 is the low half of lane 0
	assign state_words = state_q;
	assign digest_word = state_words[digest_index];

endmodule

`default_nettype wire

/* source/keccak_hash_top.sv */
// Keccak hash coprocessor top. Defaults build Keccak-512 and other widths follow from the two parameters.
`default_nettype none

module keccak_hash_top import keccak_pkg::*; #(
	parameter int RATE_WORDS   = RATE_WORDS_DEFAULT,
	parameter int DIGEST_WORDS = DIGEST_WORDS_DEFAULT
) (
	input  logic                            clk,
	input  logic                            arst_n,

	// host message port
	input  logic                            host_req,
	input  host_word_t                      host_word,
	output logic                            host_ack,

	// digest port
	output logic                            digest_valid,
	input  logic [$clog2(DIGEST_WORDS)-1:0] digest_index,
	output word_t                           digest_word
);

	// intake to buffer
	logic                   pad_valid;
	pad_word_t              pad_word;
	logic                   pad_take;

	// buffer to sponge
	logic                   block_valid;
	word_t [RATE_WORDS-1:0] block_data;
	logic                   block_first;
	logic                   block_last;
	logic                   block_take;

	keccak_word_intake i_keccak_word_intake (
		.clk       (clk),
		.arst_n    (arst_n),
		.host_req  (host_req),
		.host_word (host_word),
		.host_ack  (host_ack),
		.pad_valid (pad_valid),
		.pad_word  (pad_word),
		.pad_take  (pad_take)
	);

	keccak_block_buffer #(
		.RATE_WORDS (RATE_WORDS)
	) i_keccak_block_buffer (
		.clk         (clk),
		.arst_n      (arst_n),
		.pad_valid   (pad_valid),
		.pad_word    (pad_word),
		.pad_take    (pad_take),
		.block_valid (block_valid),
		.block_data  (block_data),
		.block_first (block_first),
		.block_last  (block_last),
		.block_take  (block_take)
	);

	keccak_sponge #(
		.RATE_WORDS   (RATE_WORDS),
		.DIGEST_WORDS (DIGEST_WORDS)
	) i_keccak_sponge (
		.clk          (clk),
		.arst_n       (arst_n),
		.block_valid  (block_valid),
		.block_data   (block_data),
		.block_first  (block_first),
		.block_last   (block_last),
		.block_take   (block_take),
		.digest_valid (digest_valid),
		.digest_index (digest_index),
		.digest_word  (digest_word)
	);

endmodule

`default_nettype wire

/* verification/keccak_ref_model.svh */
// Testbench-only sponge model with original Keccak padding that needs RATE_WORDS and DIGEST_WORDS in scope.
`ifndef KECCAK_REF_MODEL_SVH
`define KECCAK_REF_MODEL_SVH

// one message as bytes in order
typedef logic [7:0] byte_q_t [$];
// digest words with word 0 at index 0
typedef word_t [DIGEST_WORDS-1:0] digest_t;

function automatic lane_t rotate_lane(input lane_t v, input int n);
	if (n == 0) begin
		return v;
	end
	return (v << n) | (v >> (64 - n));
endfunction

//////////////////////////////////////////////////
// Keccak-f[1600] with constants built on the fly
//////////////////////////////////////////////////

function automatic state_t keccak_f1600(input state_t a_in);
	state_t     a;
	state_t     b;
	lane_t      c [5];
	lane_t      d [5];
	lane_t      rc;
	int         rot [25];
	int         x;
	int         y;
	int         nx;
	logic [7:0] lfsr;
	a = a_in;
	// rho amounts from triangular numbers along the (x,y) walk
	rot[0] = 0;
	x = 1;
	y = 0;
	for (int t = 0; t < 24; t++) begin
		rot[x + 5*y] = ((t + 1) * (t + 2) / 2) % 64;
		nx = y;
		y  = (2*x + 3*y) % 5;
		x  = nx;
	end
	// iota bits come from the x^8+x^6+x^5+x^4+1 LFSR
	lfsr = 8'h01;
	for (int r = 0; r < 24; r++) begin
		// theta
		for (int ix = 0; ix < 5; ix++) begin
			c[ix] = a[ix] ^ a[ix+5] ^ a[ix+10] ^ a[ix+15] ^ a[ix+20];
		end
		for (int ix = 0; ix < 5; ix++) begin
			d[ix] = c[(ix+4)%5] ^ rotate_lane(c[(ix+1)%5], 1);
		end
		for (int i = 0; i < 25; i++) begin
			a[i] = a[i] ^ d[i%5];
		end
		// rho and pi together
		for (int iy = 0; iy < 5; iy++) begin
			for (int ix = 0; ix < 5; ix++) begin
				b[iy + 5*((2*ix + 3*iy) % 5)] = rotate_lane(a[ix + 5*iy], rot[ix + 5*iy]);
			end
		end
		// chi
		for (int iy = 0; iy < 5; iy++) begin
			for (int ix = 0; ix < 5; ix++) begin
				a[ix + 5*iy] = b[ix + 5*iy] ^ (~b[(ix+1)%5 + 5*iy] & b[(ix+2)%5 + 5*iy]);
			end
		end
		// iota takes seven LFSR steps per round
		rc = '0;
		for (int j = 0; j < 7; j++) begin
			if (lfsr[0]) begin
				rc[(1 << j) - 1] = 1'b1;
			end
			lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
		end
		a[0] = a[0] ^ rc;
	end
	return a;
endfunction

//////////////////////////////////////////////////
// pad, absorb and squeeze
//////////////////////////////////////////////////

function automatic digest_t sponge_digest(input byte_q_t msg);
	byte_q_t pad;
	state_t  s;
	digest_t dig;
	int      nblk;
	pad = msg;
	// pad10*1 at byte level with 0x01 first and 0x80 in the last rate byte
	pad.push_back(8'h01);
	while (pad.size() % (4 * RATE_WORDS) != 0) begin
		pad.push_back(8'h00);
	end
	pad[pad.size()-1] = pad[pad.size()-1] | 8'h80;
	s    = '0;
	nblk = pad.size() / (4 * RATE_WORDS);
	for (int k = 0; k < nblk; k++) begin
		// byte i of a block goes little-endian into lane i/8
		for (int i = 0; i < 4 * RATE_WORDS; i++) begin
			s[i/8][8*(i%8) +: 8] = s[i/8][8*(i%8) +: 8] ^ pad[k*4*RATE_WORDS + i];
		end
		s = keccak_f1600(s);
	end
	for (int w = 0; w < DIGEST_WORDS; w++) begin
		dig[w] = s[w/2][32*(w%2) +: 32];
	end
	return dig;
endfunction

`endif

/* verification/keccak_hash_tb.sv */
// Directed tests run only at the default Keccak-512 widths.
`default_nettype none

module keccak_hash_tb import keccak_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RATE_WORDS   = RATE_WORDS_DEFAULT;
	localparam int DIGEST_WORDS = DIGEST_WORDS_DEFAULT;
	localparam int IDX_W        = $clog2(DIGEST_WORDS);
	localparam int CLK_PERIOD   = 40;
	// message lengths in bytes
	localparam int LEN_SHORT    = 7;
	localparam int LEN_BLOCK    = 4 * RATE_WORDS;
	localparam int LEN_RANDOM   = 150;
	localparam int LEN_FIRST    = 20;
	localparam int LEN_SECOND   = 100;

	`include "keccak_ref_model.svh"

	logic             clk = 1'b0;
	logic             arst_n;
	logic             host_req;
	host_word_t       host_word;
	logic             host_ack;
	logic             digest_valid;
	logic [IDX_W-1:0] digest_index;
	word_t            digest_word;
	logic             ack_seen;
	logic             req_seen;

	keccak_hash_top #(
		.RATE_WORDS   (RATE_WORDS),
		.DIGEST_WORDS (DIGEST_WORDS)
	) i_keccak_hash_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.host_req     (host_req),
		.host_word    (host_word),
		.host_ack     (host_ack),
		.digest_valid (digest_valid),
		.digest_index (digest_index),
		.digest_word  (digest_word)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	//////////////////////////////////////////////////
	// error handling and compares
	//////////////////////////////////////////////////

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string test, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("[FAIL] %s expected %08h actual %08h", test, expected, actual));
		end
	endtask

	task automatic check_bit(input string test, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("[FAIL] %s expected %b actual %b", test, expected, actual));
		end
	endtask

	// ack may only rise after an edge where the intake saw req high
	always @(posedge clk) begin
		if (arst_n && host_ack && !ack_seen && !req_seen) begin
			stop_on_error("host_ack rose while host_req was low");
		end
		ack_seen <= host_ack;
		req_seen <= host_req;
	end

	//////////////////////////////////////////////////
	// host side
	//////////////////////////////////////////////////

	function automatic byte_q_t random_message(input int len);
		byte_q_t msg;
		for (int i = 0; i < len; i++) begin
			msg.push_back(8'($urandom));
		end
		return msg;
	endfunction

	// one full four-phase cycle
	task automatic send_word(input host_word_t word, input bit jitter);
		if (jitter) begin
			repeat ($urandom_range(3)) @(posedge clk);
		end
		host_word <= word;
		host_req  <= 1'b1;
		do begin
			@(posedge clk);
		end while (host_ack !== 1'b1);
		if (jitter) begin
			repeat ($urandom_range(3)) @(posedge clk);
		end
		host_req <= 1'b0;
		do begin
			@(posedge clk);
		end while (host_ack !== 1'b0);
	endtask

	task automatic send_message(input byte_q_t msg, input bit jitter);
		host_word_t word;
		int         full;
		int         tail;
		full = msg.size() / 4;
		tail = msg.size() % 4;
		for (int w = 0; w < full; w++) begin
			word.data     = {msg[4*w+3], msg[4*w+2], msg[4*w+1], msg[4*w]};
			word.last     = 1'b0;
			word.byte_num = 2'd0;
			send_word(word, jitter);
		end
		// unused high bytes carry junk for the intake to mask
		word.data = $urandom;
		for (int b = 0; b < tail; b++) begin
			word.data[8*b +: 8] = msg[4*full + b];
		end
		word.last     = 1'b1;
		word.byte_num = 2'(tail);
		send_word(word, jitter);
	endtask

	task automatic read_digest(input string test, input digest_t expected);
		do begin
			@(posedge clk);
		end while (digest_valid !== 1'b1);
		for (int i = 0; i < DIGEST_WORDS; i++) begin
			digest_index <= IDX_W'(i);
			@(posedge clk);
			check_word($sformatf("%s word %0d", test, i), expected[i], digest_word);
		end
	endtask

	task automatic hash_and_check(input string test, input byte_q_t msg, input bit jitter);
		digest_t expected;
		expected = sponge_digest(msg);
		send_message(msg, jitter);
		// old digest gone once the first block is absorbed
		check_bit({test, " digest_valid low"}, 1'b0, digest_valid);
		read_digest(test, expected);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic idle_after_reset();
		repeat (8) begin
			@(posedge clk);
			check_bit("idle host_ack", 1'b0, host_ack);
			check_bit("idle digest_valid", 1'b0, digest_valid);
		end
	endtask

	task automatic empty_message();
		byte_q_t msg;
		hash_and_check("empty", msg, 1'b0);
	endtask

	task automatic short_message();
		hash_and_check("short", random_message(LEN_SHORT), 1'b0);
	endtask

	// exactly one rate block so padding needs a block of its own
	task automatic full_block_message();
		hash_and_check("one_block", random_message(LEN_BLOCK), 1'b0);
	endtask

	task automatic random_pace_message();
		hash_and_check("random_pace", random_message(LEN_RANDOM), 1'b1);
	endtask

	task automatic back_to_back_messages();
		hash_and_check("back_to_back first", random_message(LEN_FIRST), 1'b0);
		hash_and_check("back_to_back second", random_message(LEN_SECOND), 1'b0);
	endtask

	//////////////////////////////////////////////////
	// watchdog and main sequence
	//////////////////////////////////////////////////

	function automatic int blocks_of(input int len);
		return len / (4 * RATE_WORDS) + 1;
	endfunction

	initial begin : watchdog
		int limit;
		limit = 200 * (blocks_of(0) + blocks_of(LEN_SHORT) + blocks_of(LEN_BLOCK)
			+ blocks_of(LEN_RANDOM) + blocks_of(LEN_FIRST) + blocks_of(LEN_SECOND)) + 1000;
		repeat (limit) @(posedge clk);
		stop_on_error("watchdog expired, no digest arrived in time");
	end

	initial begin
		void'($urandom(87));
		arst_n       = 1'b0;
		host_req     = 1'b0;
		host_word    = '0;
		digest_index = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		idle_after_reset();
		empty_message();
		short_message();
		full_block_message();
		random_pace_message();
		back_to_back_messages();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+verification
source/keccak_pkg.sv
source/keccak_word_intake.sv
source/keccak_block_buffer.sv
source/keccak_round.sv
source/keccak_sponge.sv
source/keccak_hash_top.sv
verification/keccak_hash_tb.sv

/* Makefile */
# Verilator build and run of the Keccak hash coprocessor testbench

VERILATOR ?= verilator
TOP       ?= keccak_hash_tb
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := $(wildcard verification/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
